// File: include/pmux_defines.svh
// ====================================================================
// Pipeline mux shared constants
// Line geometry, group size, PC width, opcode values and the PC
// reported when no control-flow target exists
// ====================================================================

`ifndef PMUX_DEFINES_SVH
`define PMUX_DEFINES_SVH

// One cache line is 64 bytes, sixteen 32-bit words
`define PMUX_LINE_BITS 512
// Instruction slots handed to decode per group
`define PMUX_SLOTS 4
`define PMUX_PC_BITS 32

// Fallback PC for target and return when nothing applies
`define PMUX_RESET_PC 32'hFFFC0000

// Seven-bit major opcodes seen by this stage
// NOP is deliberately nonzero so an all-zero word is not a NOP
`define PMUX_OP_NOP 7'h0B
`define PMUX_OP_BRA 7'h20
`define PMUX_OP_BSR 7'h21
`define PMUX_OP_JMP 7'h22
`define PMUX_OP_JSR 7'h23
`define PMUX_OP_JSRR 7'h24
`define PMUX_OP_RET 7'h25

`endif

// File: hdl/pmux_pkg.sv
// ====================================================================
// Pipeline mux types
// Instruction, slot, group, single-step and flow result types
// shared by the fetch-to-decode stage
// ====================================================================

`include "pmux_defines.svh"

package pmux_pkg;

	// Fetch address, byte granular
	typedef logic [`PMUX_PC_BITS-1:0] pc_t;

	// Reduced instruction word
	// For BRA and BSR the field is a signed word displacement
	// For JMP and JSR the field is an absolute word address
	typedef struct packed {
		logic [6:0]  opcode;
		logic [24:0] field;
	} instr_t;

	// The word substituted for padding and redundant groups
	localparam instr_t NOP_INSTR = '{opcode: `PMUX_OP_NOP, field: 25'd0};

	// One decode slot
	// ssm marks a slot that single-step held back
	typedef struct packed {
		instr_t ins;
		pc_t    pc;
		logic   v;
		logic   ssm;
	} slot_t;

	// Slot 0 sits in the low bits, so index k is slot k
	typedef slot_t [`PMUX_SLOTS-1:0] group_t;

	// How many slots single-step lets through this cycle
	typedef enum logic [1:0] {
		pass_all  = 2'd0,
		pass_one  = 2'd1,
		pass_none = 2'd2
	} step_mode_t;

	// Single-step FSM state
	typedef enum logic {
		st_run  = 1'b0,
		st_hold = 1'b1
	} step_state_t;

	// Result of the control-flow scan over one group
	typedef struct packed {
		logic do_jump;
		logic do_call;
		logic do_ret;
		pc_t  target;
		pc_t  ret_pc;
	} flow_t;

endpackage

// File: hdl/line_aligner.sv
// ====================================================================
// Line aligner
// Shifts the cache line down to the fetch PC word, pads past the end
// of the line with NOPs and flags a group that repeats the last one
// ====================================================================

`timescale 1ns/10ps

`include "pmux_defines.svh"

module line_aligner import pmux_pkg::*; (
	input  logic                     clk,
	input  logic                     rst_i,
	input  logic                     en_i,
	input  logic [`PMUX_LINE_BITS-1:0] line_i,
	input  pc_t                      fetch_pc_i,
	output instr_t [`PMUX_SLOTS-1:0] aligned_o,
	output logic                     redundant_o
);

	// Word index within the line comes from the low PC bits above the byte offset
	localparam int LINE_WORDS = `PMUX_LINE_BITS / 32;
	localparam int IDX_BITS   = $clog2(LINE_WORDS);

	logic [IDX_BITS-1:0]                     word_idx;
	logic [`PMUX_LINE_BITS+`PMUX_SLOTS*32-1:0] padded_line;
	logic [`PMUX_LINE_BITS+`PMUX_SLOTS*32-1:0] shifted_line;
	pc_t                                     prev_pc;
	instr_t [`PMUX_SLOTS-1:0]                prev_aligned;

	assign word_idx = fetch_pc_i[IDX_BITS+1:2];

	// ================================================================
	// Alignment
	// ================================================================

	// A full group of NOPs above the line covers any overrun
	assign padded_line  = {{`PMUX_SLOTS{NOP_INSTR}}, line_i};
	assign shifted_line = padded_line >> {word_idx, 5'd0};
	assign aligned_o    = shifted_line[`PMUX_SLOTS*32-1:0];

	// ================================================================
	// Repeat detection
	// ================================================================

	// Remember what was presented at the last advancing edge
	always_ff @(posedge clk) begin
		if (rst_i) begin
			prev_pc      <= '0;
			prev_aligned <= '0;
		end else if (en_i) begin
			prev_pc      <= fetch_pc_i;
			prev_aligned <= aligned_o;
		end
	end

	// Same PC and same words means the cache handed us the group again
	assign redundant_o = (prev_pc == fetch_pc_i) && (prev_aligned == aligned_o);

endmodule

// File: hdl/step_ctrl.sv
// ====================================================================
// Single-step controller
// Lets exactly one instruction through when single-step is raised
// and then holds the stream until it drops again
// ====================================================================

`timescale 1ns/10ps

`include "pmux_defines.svh"

module step_ctrl import pmux_pkg::*; (
	input  logic       clk,
	input  logic       rst_i,
	input  logic       en_i,
	input  logic       ssm_i,
	output step_mode_t step_mode_o
);

	step_state_t state_q;
	step_state_t state_d;

	// Mode is a pure function of state and the step level
	always_comb begin
		state_d     = state_q;
		step_mode_o = pass_all;
		if (!ssm_i) begin
			// Stepping is off, run freely and rearm
			step_mode_o = pass_all;
			state_d     = st_run;
		end else begin
			case (state_q)
				st_run: begin
					// First stepped cycle releases slot 0 only
					step_mode_o = pass_one;
					state_d     = st_hold;
				end
				st_hold: begin
					step_mode_o = pass_none;
				end
				default: begin
					step_mode_o = pass_none;
					state_d     = st_run;
				end
			endcase
		end
	end

	// State only moves when the stage advances
	always_ff @(posedge clk) begin
		if (rst_i)
			state_q <= st_run;
		else if (en_i)
			state_q <= state_d;
	end

endmodule

// File: hdl/slot_build.sv
// ====================================================================
// Slot builder
// Gives each aligned word its PC, applies interrupt, stomp,
// branch-miss and single-step invalidation and registers the group
// ====================================================================

`timescale 1ns/10ps

`include "pmux_defines.svh"

module slot_build import pmux_pkg::*; (
	input  logic                     clk,
	input  logic                     rst_i,
	input  logic                     en_i,
	input  logic                     irq_i,
	input  logic                     nmi_i,
	input  logic                     stomp_i,
	input  logic                     branch_miss_i,
	input  pc_t                      miss_pc_i,
	input  pc_t                      fetch_pc_i,
	input  instr_t [`PMUX_SLOTS-1:0] aligned_i,
	input  logic                     redundant_i,
	input  step_mode_t               step_mode_i,
	output group_t                   group_o,
	output logic                     nop_o
);

	group_t                   group_d;
	logic                     kill_all;
	instr_t [`PMUX_SLOTS-1:0] ins_q;
	pc_t    [`PMUX_SLOTS-1:0] pc_q;
	logic   [`PMUX_SLOTS-1:0] valid_q;
	logic   [`PMUX_SLOTS-1:0] ssm_q;

	// Interrupts and stomp wipe the whole group
	assign kill_all = irq_i | nmi_i | stomp_i;

	always_comb begin
		pc_t  slot_pc;
		logic step_ok;
		logic miss_ok;
		for (int k = 0; k < `PMUX_SLOTS; k++) begin
			slot_pc = fetch_pc_i + pc_t'(4 * k);
			step_ok = (step_mode_i == pass_all) || (step_mode_i == pass_one && k == 0);
			// Slots ahead of the miss address belong to the wrong path
			miss_ok = !branch_miss_i || (miss_pc_i <= slot_pc);
			group_d[k].ins = redundant_i ? NOP_INSTR : aligned_i[k];
			group_d[k].pc  = slot_pc;
			group_d[k].v   = !kill_all && step_ok && miss_ok;
			group_d[k].ssm = (step_mode_i == pass_none) ||
				(step_mode_i == pass_one && k != 0);
		end
	end

	// ================================================================
	// Decode-facing registers
	// ================================================================

	always_ff @(posedge clk) begin
		if (en_i) begin
			for (int k = 0; k < `PMUX_SLOTS; k++) begin
				ins_q[k] <= group_d[k].ins;
				pc_q[k]  <= group_d[k].pc;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst_i) begin
			valid_q <= '0;
			ssm_q   <= '0;
			nop_o   <= 1'b0;
		end else if (en_i) begin
			for (int k = 0; k < `PMUX_SLOTS; k++) begin
				valid_q[k] <= group_d[k].v;
				ssm_q[k]   <= group_d[k].ssm;
			end
			nop_o <= stomp_i;
		end
	end

	// Reassemble the registered fields into slot order
	always_comb begin
		for (int k = 0; k < `PMUX_SLOTS; k++) begin
			group_o[k].ins = ins_q[k];
			group_o[k].pc  = pc_q[k];
			group_o[k].v   = valid_q[k];
			group_o[k].ssm = ssm_q[k];
		end
	end

endmodule

// File: hdl/flow_detect.sv
// ====================================================================
// Flow detector
// Scans the registered group in slot order for the first valid jump,
// call or return and works out the target and the return PC
// ====================================================================

`timescale 1ns/10ps

`include "pmux_defines.svh"

module flow_detect import pmux_pkg::*; (
	input  group_t group_i,
	output flow_t  flow_o
);

	logic [`PMUX_SLOTS-1:0] is_jump;
	logic [`PMUX_SLOTS-1:0] is_call;
	logic [`PMUX_SLOTS-1:0] is_ret;
	logic [`PMUX_SLOTS-1:0] is_flow;
	pc_t  [`PMUX_SLOTS-1:0] slot_tgt;

	// ================================================================
	// Per-slot decode
	// ================================================================

	// Anything that redirects fetch to a new PC
	function automatic logic dec_jump(input logic [6:0] op);
		return op == `PMUX_OP_BRA || op == `PMUX_OP_BSR ||
			op == `PMUX_OP_JMP || op == `PMUX_OP_JSR;
	endfunction

	// Anything that pushes a return address, JSRR included
	function automatic logic dec_call(input logic [6:0] op);
		return op == `PMUX_OP_BSR || op == `PMUX_OP_JSR || op == `PMUX_OP_JSRR;
	endfunction

	// Target from the instruction word itself
	function automatic pc_t dec_target(input instr_t ins, input pc_t pc);
		pc_t disp;
		pc_t absol;
		disp  = {{(`PMUX_PC_BITS-27){ins.field[24]}}, ins.field, 2'b00};
		absol = {{(`PMUX_PC_BITS-27){1'b0}}, ins.field, 2'b00};
		case (ins.opcode)
			`PMUX_OP_BRA, `PMUX_OP_BSR: return pc + disp;
			`PMUX_OP_JMP, `PMUX_OP_JSR: return absol;
			default: return `PMUX_RESET_PC;
		endcase
	endfunction

	always_comb begin
		for (int k = 0; k < `PMUX_SLOTS; k++) begin
			is_jump[k]  = dec_jump(group_i[k].ins.opcode);
			is_call[k]  = dec_call(group_i[k].ins.opcode);
			is_ret[k]   = group_i[k].ins.opcode == `PMUX_OP_RET;
			// Invalid slots never steer the flow
			is_flow[k]  = group_i[k].v && (is_jump[k] || is_call[k] || is_ret[k]);
			slot_tgt[k] = dec_target(group_i[k].ins, group_i[k].pc);
		end
	end

	// ================================================================
	// Slot priority
	// ================================================================

	// Lowest numbered flow slot wins, later ones are ignored
	always_comb begin
		logic found;
		found          = 1'b0;
		flow_o.do_jump = 1'b0;
		flow_o.do_call = 1'b0;
		flow_o.do_ret  = 1'b0;
		flow_o.target  = `PMUX_RESET_PC;
		flow_o.ret_pc  = `PMUX_RESET_PC;
		for (int k = 0; k < `PMUX_SLOTS; k++) begin
			if (!found && is_flow[k]) begin
				found          = 1'b1;
				flow_o.do_jump = is_jump[k];
				flow_o.do_call = is_call[k];
				flow_o.do_ret  = is_ret[k];
				flow_o.target  = slot_tgt[k];
				// Return lands on the word after the call
				if (is_call[k])
					flow_o.ret_pc = group_i[k].pc + pc_t'(4);
			end
		end
	end

endmodule

// File: hdl/pipeline_mux.sv
// ====================================================================
// Pipeline mux
// Fetch-to-decode stage: aligns the cache line, builds a validated
// four-slot group for decode and reports its first control transfer
// ====================================================================

`timescale 1ns/10ps

`include "pmux_defines.svh"

module pipeline_mux import pmux_pkg::*; (
	input  logic                       clk,
	input  logic                       rst_i,
	input  logic                       en_i,
	input  logic [`PMUX_LINE_BITS-1:0] line_i,
	input  pc_t                        fetch_pc_i,
	input  logic                       irq_i,
	input  logic                       nmi_i,
	input  logic                       stomp_i,
	input  logic                       branch_miss_i,
	input  pc_t                        miss_pc_i,
	input  logic                       ssm_i,
	output group_t                     group_o,
	output flow_t                      flow_o,
	output logic                       nop_o
);

	instr_t [`PMUX_SLOTS-1:0] aligned;
	logic                     redundant;
	step_mode_t               step_mode;

	line_aligner i_line_aligner (
		.clk         (clk),
		.rst_i       (rst_i),
		.en_i        (en_i),
		.line_i      (line_i),
		.fetch_pc_i  (fetch_pc_i),
		.aligned_o   (aligned),
		.redundant_o (redundant)
	);

	step_ctrl i_step_ctrl (
		.clk         (clk),
		.rst_i       (rst_i),
		.en_i        (en_i),
		.ssm_i       (ssm_i),
		.step_mode_o (step_mode)
	);

	// Only stage with latency, everything downstream follows its output
	slot_build i_slot_build (
		.clk           (clk),
		.rst_i         (rst_i),
		.en_i          (en_i),
		.irq_i         (irq_i),
		.nmi_i         (nmi_i),
		.stomp_i       (stomp_i),
		.branch_miss_i (branch_miss_i),
		.miss_pc_i     (miss_pc_i),
		.fetch_pc_i    (fetch_pc_i),
		.aligned_i     (aligned),
		.redundant_i   (redundant),
		.step_mode_i   (step_mode),
		.group_o       (group_o),
		.nop_o         (nop_o)
	);

	flow_detect i_flow_detect (
		.group_i (group_o),
		.flow_o  (flow_o)
	);

endmodule

// File: test/tb_pipeline_mux.sv
// ====================================================================
// Pipeline mux testbench
// Directed tests for alignment, repeat suppression, invalidation,
// single-step and control-flow detection against a reference model
// ====================================================================

`timescale 1ns/10ps

`include "pmux_defines.svh"

module tb_pipeline_mux import pmux_pkg::*; ();

	localparam int LINE_WORDS = `PMUX_LINE_BITS / 32;
	localparam int MAX_CYCLES = 2000;
	localparam logic [31:0] LFSR_TAPS = 32'hB4BCD35C;
	localparam instr_t NOP_WORD = '{opcode: `PMUX_OP_NOP, field: 25'd0};

	typedef logic [`PMUX_LINE_BITS-1:0] line_t;
	typedef instr_t [`PMUX_SLOTS-1:0] words_t;

	// Everything presented to the stage in one cycle
	typedef struct packed {
		logic  en;
		line_t line;
		pc_t   pc;
		logic  irq;
		logic  nmi;
		logic  stomp;
		logic  miss;
		pc_t   miss_pc;
		logic  ssm;
	} stim_t;

	logic   clk;
	logic   rst_i;
	logic   en_i;
	line_t  line_i;
	pc_t    fetch_pc_i;
	logic   irq_i;
	logic   nmi_i;
	logic   stomp_i;
	logic   branch_miss_i;
	pc_t    miss_pc_i;
	logic   ssm_i;
	group_t group_o;
	flow_t  flow_o;
	logic   nop_o;

	// Reference model state, as it stands after the last enabled edge
	pc_t    m_prev_pc;
	words_t m_prev_words;
	logic   m_hold;
	logic   have_data;
	group_t exp_group;
	logic   exp_nop;

	logic [31:0] lfsr_state = 32'h1328;
	int          mismatch_count;
	int          fail_count;
	string       test_name;

	pipeline_mux i_dut (
		.clk           (clk),
		.rst_i         (rst_i),
		.en_i          (en_i),
		.line_i        (line_i),
		.fetch_pc_i    (fetch_pc_i),
		.irq_i         (irq_i),
		.nmi_i         (nmi_i),
		.stomp_i       (stomp_i),
		.branch_miss_i (branch_miss_i),
		.miss_pc_i     (miss_pc_i),
		.ssm_i         (ssm_i),
		.group_o       (group_o),
		.flow_o        (flow_o),
		.nop_o         (nop_o)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// ================================================================
	// Stimulus helpers
	// ================================================================

	// Galois LFSR stepped once for every bit handed out
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] val;
		logic        b;
		val = '0;
		for (int i = 0; i < n; i++) begin
			b = lfsr_state[0];
			lfsr_state = (lfsr_state >> 1) ^ (b ? LFSR_TAPS : 32'h0);
			val = {val[30:0], b};
		end
		return val;
	endfunction

	function automatic instr_t make_instr(input logic [6:0] op);
		logic [31:0] r;
		r = rand_bits(25);
		return '{opcode: op, field: r[24:0]};
	endfunction

	// Random fields under a NOP opcode so no word steers the flow by accident
	function automatic line_t rand_line();
		line_t l;
		for (int w = 0; w < LINE_WORDS; w++)
			l[w*32 +: 32] = make_instr(`PMUX_OP_NOP);
		return l;
	endfunction

	function automatic line_t put_word(input line_t line, input int idx, input instr_t ins);
		line_t l;
		l = line;
		l[idx*32 +: 32] = ins;
		return l;
	endfunction

	function automatic stim_t base_stim();
		stim_t s;
		s = '0;
		s.en = 1'b1;
		s.line = rand_line();
		return s;
	endfunction

	// ================================================================
	// Reference model
	// ================================================================

	// Slot k reads line word (PC word index + k) and words past the end read as NOP
	function automatic words_t align_line(input line_t line, input pc_t pc);
		words_t w;
		int     idx;
		for (int k = 0; k < `PMUX_SLOTS; k++) begin
			idx = int'((pc >> 2) % LINE_WORDS) + k;
			w[k] = (idx < LINE_WORDS) ? instr_t'(line[idx*32 +: 32]) : NOP_WORD;
		end
		return w;
	endfunction

	function automatic void model_edge(input stim_t s);
		words_t words;
		logic   repeat_grp;
		pc_t    spc;
		if (s.en) begin
			words = align_line(s.line, s.pc);
			repeat_grp = (s.pc == m_prev_pc) && (words == m_prev_words);
			for (int k = 0; k < `PMUX_SLOTS; k++) begin
				spc = s.pc + pc_t'(4 * k);
				exp_group[k].ins = repeat_grp ? NOP_WORD : words[k];
				exp_group[k].pc = spc;
				// The first stepped edge lets slot 0 through and later ones hold every slot
				exp_group[k].ssm = s.ssm && (m_hold || k != 0);
				exp_group[k].v = !(s.irq || s.nmi || s.stomp) && !exp_group[k].ssm &&
					!(s.miss && s.miss_pc > spc);
			end
			exp_nop = s.stomp;
			m_prev_pc = s.pc;
			m_prev_words = words;
			m_hold = s.ssm;
			have_data = 1'b1;
		end
	endfunction

	function automatic flow_t expect_flow(input group_t g);
		flow_t              f;
		logic [6:0]         op;
		logic signed [31:0] disp;
		logic               done;
		f = '{do_jump: 1'b0, do_call: 1'b0, do_ret: 1'b0,
			target: `PMUX_RESET_PC, ret_pc: `PMUX_RESET_PC};
		done = 1'b0;
		for (int k = 0; k < `PMUX_SLOTS; k++) begin
			op = g[k].ins.opcode;
			if (!done && g[k].v && op inside {`PMUX_OP_BRA, `PMUX_OP_BSR, `PMUX_OP_JMP,
					`PMUX_OP_JSR, `PMUX_OP_JSRR, `PMUX_OP_RET}) begin
				done = 1'b1;
				f.do_jump = op inside {`PMUX_OP_BRA, `PMUX_OP_BSR, `PMUX_OP_JMP, `PMUX_OP_JSR};
				f.do_call = op inside {`PMUX_OP_BSR, `PMUX_OP_JSR, `PMUX_OP_JSRR};
				f.do_ret = (op == `PMUX_OP_RET);
				disp = 32'($signed(g[k].ins.field));
				if (op == `PMUX_OP_BRA || op == `PMUX_OP_BSR)
					f.target = g[k].pc + pc_t'(disp * 4);
				else if (op == `PMUX_OP_JMP || op == `PMUX_OP_JSR)
					f.target = pc_t'(g[k].ins.field) * 4;
				if (f.do_call)
					f.ret_pc = g[k].pc + 32'd4;
			end
		end
		return f;
	endfunction

	// ================================================================
	// Compare tasks
	// ================================================================

	task automatic check_group(input group_t got, input group_t exp);
		for (int k = 0; k < `PMUX_SLOTS; k++) begin
			if (got[k] !== exp[k]) begin
				mismatch_count++;
				$display("mismatch at %0t in %s: slot %0d got ins=%h pc=%h v=%b ssm=%b",
					$time, test_name, k, got[k].ins, got[k].pc, got[k].v, got[k].ssm);
				$display("  expected ins=%h pc=%h v=%b ssm=%b",
					exp[k].ins, exp[k].pc, exp[k].v, exp[k].ssm);
			end
		end
	endtask

	task automatic check_flow(input flow_t got, input flow_t exp);
		if (got !== exp) begin
			mismatch_count++;
			$display("mismatch at %0t in %s: flow got j=%b c=%b r=%b target=%h ret_pc=%h",
				$time, test_name, got.do_jump, got.do_call, got.do_ret, got.target, got.ret_pc);
			$display("  expected j=%b c=%b r=%b target=%h ret_pc=%h",
				exp.do_jump, exp.do_call, exp.do_ret, exp.target, exp.ret_pc);
		end
	endtask

	task automatic check_bit(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			mismatch_count++;
			$display("mismatch at %0t in %s: %s got %b expected %b",
				$time, test_name, what, got, exp);
		end
	endtask

	// ================================================================
	// Sequencing
	// ================================================================

	task automatic reset_dut();
		test_name = "reset";
		rst_i <= 1'b1;
		en_i <= 1'b0;
		line_i <= '0;
		fetch_pc_i <= '0;
		irq_i <= 1'b0;
		nmi_i <= 1'b0;
		stomp_i <= 1'b0;
		branch_miss_i <= 1'b0;
		miss_pc_i <= '0;
		ssm_i <= 1'b0;
		for (int n = 0; n < 4; n++)
			@(posedge clk);
		rst_i <= 1'b0;
		m_prev_pc = '0;
		m_prev_words = '0;
		m_hold = 1'b0;
		have_data = 1'b0;
		exp_group = '0;
		exp_nop = 1'b0;
		@(negedge clk);
		for (int k = 0; k < `PMUX_SLOTS; k++) begin
			check_bit(group_o[k].v, 1'b0, "valid bit");
			check_bit(group_o[k].ssm, 1'b0, "ssm bit");
		end
		check_bit(nop_o, 1'b0, "nop_o");
		check_flow(flow_o, expect_flow(exp_group));
	endtask

	// The DUT samples these inputs at the next edge, so each call checks the previous one
	task automatic step(input stim_t s);
		@(posedge clk);
		en_i <= s.en;
		line_i <= s.line;
		fetch_pc_i <= s.pc;
		irq_i <= s.irq;
		nmi_i <= s.nmi;
		stomp_i <= s.stomp;
		branch_miss_i <= s.miss;
		miss_pc_i <= s.miss_pc;
		ssm_i <= s.ssm;
		@(negedge clk);
		if (have_data)
			check_group(group_o, exp_group);
		check_flow(flow_o, expect_flow(exp_group));
		check_bit(nop_o, exp_nop, "nop_o");
		model_edge(s);
	endtask

	task automatic finish_run();
		$display("Error counts: %0d mismatches, %0d other failures", mismatch_count, fail_count);
		if (mismatch_count + fail_count == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	endtask

	// ================================================================
	// Directed tests
	// ================================================================

	// Word indices 13 to 15 run off the end of the line and pick up padding
	task automatic test_alignment();
		stim_t s;
		pc_t   pcs [7];
		pcs = '{32'h1000, 32'h1004, 32'h1024, 32'h1030, 32'h1034, 32'h1038, 32'h103C};
		test_name = "alignment";
		foreach (pcs[i]) begin
			s = base_stim();
			s.pc = pcs[i];
			step(s);
		end
	endtask

	task automatic test_repeat_hold();
		stim_t s;
		test_name = "repeat";
		s = base_stim();
		s.pc = 32'h2008;
		step(s);
		step(s);
		// Same PC with different words is a new group
		s.line = rand_line();
		step(s);
		test_name = "hold";
		s.en = 1'b0;
		s.pc = 32'h2100;
		s.line = rand_line();
		step(s);
		step(s);
		s.en = 1'b1;
		step(s);
	endtask

	task automatic test_invalidation();
		stim_t s;
		test_name = "interrupt";
		s = base_stim();
		s.irq = 1'b1;
		step(s);
		s = base_stim();
		s.nmi = 1'b1;
		step(s);
		test_name = "stomp";
		s = base_stim();
		s.stomp = 1'b1;
		step(s);
		test_name = "branch miss";
		s = base_stim();
		s.pc = 32'h3040;
		s.miss = 1'b1;
		s.miss_pc = 32'h3048;
		step(s);
		s.miss_pc = 32'h3020;
		step(s);
		s.miss_pc = 32'h3050;
		step(s);
	endtask

	task automatic test_single_step();
		stim_t s;
		test_name = "single step";
		for (int n = 0; n < 6; n++) begin
			s = base_stim();
			s.pc = 32'h5000 + pc_t'(4 * n);
			// Raised for four cycles, dropped for one, then raised again
			s.ssm = (n != 4);
			// A stall with stepping raised must leave the FSM ready to pass slot 0
			s.en = (n != 0);
			step(s);
		end
	endtask

	task automatic test_flow();
		stim_t      s;
		logic [6:0] ops [6];
		ops = '{`PMUX_OP_BRA, `PMUX_OP_BSR, `PMUX_OP_JMP,
			`PMUX_OP_JSR, `PMUX_OP_JSRR, `PMUX_OP_RET};
		test_name = "flow position";
		for (int o = 0; o < 6; o++) begin
			for (int k = 0; k < `PMUX_SLOTS; k++) begin
				s = base_stim();
				s.pc = 32'h6008 + pc_t'(64 * (o * 4 + k));
				s.line = put_word(s.line, 2 + k, make_instr(ops[o]));
				step(s);
			end
		end
		// Two transfers in one group and the lower slot wins
		test_name = "flow priority";
		s = base_stim();
		s.pc = 32'h7010;
		s.line = put_word(s.line, 5, make_instr(`PMUX_OP_BSR));
		s.line = put_word(s.line, 7, make_instr(`PMUX_OP_JMP));
		step(s);
		// A call in a slot killed by the miss is skipped in favour of the return
		test_name = "flow invalid slot";
		s = base_stim();
		s.pc = 32'h7100;
		s.miss = 1'b1;
		s.miss_pc = 32'h7104;
		s.line = put_word(s.line, 0, make_instr(`PMUX_OP_JSR));
		s.line = put_word(s.line, 2, make_instr(`PMUX_OP_RET));
		step(s);
	endtask

	initial begin : watchdog
		int n;
		n = 0;
		while (n < MAX_CYCLES) begin
			@(posedge clk);
			n++;
		end
		$display("Timeout: the test sequence did not finish within %0d clock cycles", MAX_CYCLES);
		fail_count++;
		finish_run();
	end

	initial begin : main
		stim_t s;
		mismatch_count = 0;
		fail_count = 0;
		reset_dut();
		test_alignment();
		test_repeat_hold();
		test_invalidation();
		test_single_step();
		test_flow();
		// One stalled cycle so the last group gets its check
		test_name = "drain";
		s = base_stim();
		s.en = 1'b0;
		step(s);
		finish_run();
	end

endmodule

// File: project.f
+incdir+include
hdl/pmux_pkg.sv
hdl/line_aligner.sv
hdl/step_ctrl.sv
hdl/slot_build.sv
hdl/flow_detect.sv
hdl/pipeline_mux.sv
test/tb_pipeline_mux.sv

// File: Makefile
# Verilator simulation of the pipeline mux stage
# Any variable below can be overridden on the make command line

VERILATOR ?= verilator
TOP       ?= tb_pipeline_mux
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Finished with no errors
VFLAGS    ?= --binary --timing

.PHONY: sim clean

# The run passes only when the log holds the pass line
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o $(TOP)
	./$(OBJ_DIR)/$(TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
